// File: simple_exec.f
+incdir+common
common/simple_processor_pkg.sv
design/alu/alu_shift.sv
design/alu/alu_arith_logic.sv
design/alu/alu.sv
design/reg_file.sv
design/exec_pipe.sv
design/simple_exec_top.sv
bench/tb_clk_gen.sv
bench/simple_exec_tb.sv

// File: Makefile
# Verilator build and run for the execute slice

VERILATOR ?= verilator
TOP       ?= simple_exec_tb
FILELIST  ?= simple_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/simple_exec_tb.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Execute slice testbench
//////////////////////////////////////////////////

`include "simple_processor_cfg.svh"

module simple_exec_tb;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait loop

  logic                            clk, rst_n;
  logic                            iss_valid, iss_credit, res_credit, res_valid;
  simple_processor_pkg::func_t     iss_func;
  simple_processor_pkg::reg_addr_t iss_rs1, iss_rs2, iss_rd, res_rd;
  simple_processor_pkg::imm_t      iss_imm;
  simple_processor_pkg::data_t     res_data;

  simple_processor_pkg::data_t     ref_regs [`REG_COUNT];  // Reference register file
  simple_processor_pkg::reg_addr_t exp_rd_q [$];           // Expected results in issue order
  simple_processor_pkg::data_t     exp_data_q [$];
  int     issued, credit_pulses, results_seen, owed;
  logic   withhold, gap_mode;  // Consumer behavior
  integer seed, gap_seed;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  simple_exec_top i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .iss_valid_i  (iss_valid),
    .iss_func_i   (iss_func),
    .iss_rs1_i    (iss_rs1),
    .iss_rs2_i    (iss_rs2),
    .iss_rd_i     (iss_rd),
    .iss_imm_i    (iss_imm),
    .iss_credit_o (iss_credit),
    .res_credit_i (res_credit),
    .res_valid_o  (res_valid),
    .res_rd_o     (res_rd),
    .res_data_o   (res_data)
  );

  //////////////////////////////////////////////////
  // Reporting and reference model
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic simple_processor_pkg::data_t model_result(
    input simple_processor_pkg::func_t f,
    input simple_processor_pkg::data_t a,
    input simple_processor_pkg::data_t b,
    input simple_processor_pkg::imm_t  imm
  );
    simple_processor_pkg::data_t imm_x;
    simple_processor_pkg::data_t amt;
    imm_x = $signed(imm);  // Sign-extended to full width
    amt   = (f == simple_processor_pkg::SLLI || f == simple_processor_pkg::SLRI) ? imm_x : b;
    case (f)
      simple_processor_pkg::ADD:  return a + b;
      simple_processor_pkg::SUB:  return a - b;
      simple_processor_pkg::AND:  return a & b;
      simple_processor_pkg::OR:   return a | b;
      simple_processor_pkg::XOR:  return a ^ b;
      simple_processor_pkg::ADDI: return a + imm_x;
      simple_processor_pkg::SLL,
      simple_processor_pkg::SLLI: return (amt >= `DATA_WIDTH) ? '0 : (a << amt);
      default:                    return (amt >= `DATA_WIDTH) ? '0 : (a >> amt);
    endcase
  endfunction

  // Arithmetic group at 0..5 and shifts at 6..9
  function automatic simple_processor_pkg::func_t pick_func(input int sel);
    case (sel)
      0:       return simple_processor_pkg::ADD;
      1:       return simple_processor_pkg::SUB;
      2:       return simple_processor_pkg::AND;
      3:       return simple_processor_pkg::OR;
      4:       return simple_processor_pkg::XOR;
      5:       return simple_processor_pkg::ADDI;
      6:       return simple_processor_pkg::SLL;
      7:       return simple_processor_pkg::SLLI;
      8:       return simple_processor_pkg::SLR;
      default: return simple_processor_pkg::SLRI;
    endcase
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  //////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////

  // Drives on the falling edge and leaves valid high for a back-to-back follower
  task automatic issue_op(input simple_processor_pkg::func_t f,
                          input int rs1, input int rs2, input int rd, input int imm);
    int waited;
    simple_processor_pkg::data_t exp;
    waited = 0;
    @(negedge clk);
    while (`RES_DEPTH - issued + credit_pulses <= 0) begin
      iss_valid = 1'b0;  // Out of credits
      if (waited == TIMEOUT) abort_run("Timed out waiting for an issue credit");
      waited++;
      @(negedge clk);
    end
    iss_valid = 1'b1;
    iss_func  = f;
    iss_rs1   = simple_processor_pkg::reg_addr_t'(rs1);
    iss_rs2   = simple_processor_pkg::reg_addr_t'(rs2);
    iss_rd    = simple_processor_pkg::reg_addr_t'(rd);
    iss_imm   = simple_processor_pkg::imm_t'(imm);
    issued++;
    exp = model_result(f, ref_regs[rs1], ref_regs[rs2], iss_imm);
    if (rd != 0) ref_regs[rd] = exp;  // r0 stays zero
    exp_rd_q.push_back(iss_rd);
    exp_data_q.push_back(exp);
  endtask

  task automatic random_op(input int first, input int span);
    int f, rs1, rs2, rd, imm;
    f   = first + rand_below(span);
    rs1 = rand_below(32);
    rs2 = rand_below(32);
    rd  = 1 + rand_below(31);
    imm = rand_below(64);
    issue_op(pick_func(f), rs1, rs2, rd, imm);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      iss_valid = 1'b0;
    end
  endtask

  // All results seen and all issue credits back
  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_rd_q.size() != 0 || issued != credit_pulses) begin
      if (waited == TIMEOUT) abort_run("Timed out waiting for results to drain");
      waited++;
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitors and consumer
  //////////////////////////////////////////////////

  // Each pulse frees the slot of a result already delivered
  always @(posedge clk) begin
    if (rst_n === 1'b1 && iss_credit === 1'b1) begin
      credit_pulses++;  // Registered pulse
      if (credit_pulses > results_seen) begin
        abort_run("Issue credit returned with no result delivered");
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && res_valid === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        abort_run("Result delivered with no instruction outstanding");
      end else begin
        check_value("result register", res_rd, exp_rd_q.pop_front());
        check_value("result data", res_data, exp_data_q.pop_front());
        results_seen++;
      end
    end
  end

  // One credit back per received result after an optional random gap
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (res_valid === 1'b1) owed++;
      if (owed > 0 && !withhold && !(gap_mode && ($random(gap_seed) & 3) != 0)) begin
        res_credit = 1'b1;
        owed--;
      end else begin
        res_credit = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int waited;
    int seen_before;
    iss_valid = 1'b0;
    iss_func  = simple_processor_pkg::ADD;
    iss_rs1   = '0;
    iss_rs2   = '0;
    iss_rd    = '0;
    iss_imm   = '0;
    res_credit    = 1'b0;
    withhold      = 1'b0;
    gap_mode      = 1'b0;
    issued        = 0;
    credit_pulses = 0;
    results_seen  = 0;
    owed          = 0;
    seed          = 32'h76;
    gap_seed      = 32'h76;
    for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;

    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited == TIMEOUT) abort_run("Reset was never released");
      waited++;
      @(negedge clk);
    end

    // Quiet outputs after reset and zero registers
    repeat (5) begin
      @(negedge clk);
      check_value("res_valid after reset", res_valid, 0);
      check_value("iss_credit after reset", iss_credit, 0);
    end
    issue_op(simple_processor_pkg::ADD, 2, 3, 1, 0);
    issue_op(simple_processor_pkg::XOR, 4, 5, 6, 0);
    issue_op(simple_processor_pkg::SLR, 7, 8, 9, 0);
    issue_op(simple_processor_pkg::SUB, 10, 11, 12, 0);
    drain();

    // ADDI and ADD chains with wraparound
    issue_op(simple_processor_pkg::ADDI, 0, 0, 1, 5);
    issue_op(simple_processor_pkg::ADDI, 1, 0, 2, 6'h3d);  // Minus 3
    issue_op(simple_processor_pkg::ADD, 1, 2, 3, 0);
    issue_op(simple_processor_pkg::ADDI, 0, 0, 4, 6'h3f);  // All ones
    issue_op(simple_processor_pkg::ADDI, 4, 0, 5, 1);      // Wraps to zero
    issue_op(simple_processor_pkg::ADD, 4, 4, 6, 0);
    issue_op(simple_processor_pkg::SUB, 0, 1, 7, 0);
    drain();

    // Random register contents then random arithmetic under consumer gaps
    for (int r = 1; r < `REG_COUNT; r++) begin
      issue_op(simple_processor_pkg::ADDI, 0, 0, r, rand_below(64));
      issue_op(simple_processor_pkg::SLLI, r, 0, r, rand_below(27));
      issue_op(simple_processor_pkg::XOR, r, rand_below(32), r, 0);
    end
    gap_mode = 1'b1;
    repeat (60) random_op(0, 6);
    drain();
    gap_mode = 1'b0;

    // Shifts including out-of-range and negative amounts
    issue_op(simple_processor_pkg::ADDI, 0, 0, 20, 31);
    issue_op(simple_processor_pkg::ADDI, 20, 0, 21, 1);    // 32
    issue_op(simple_processor_pkg::ADDI, 0, 0, 22, 6'h3f); // Huge amount
    issue_op(simple_processor_pkg::ADDI, 21, 0, 23, 8);    // 40
    issue_op(simple_processor_pkg::ADDI, 0, 0, 24, 6'h39);
    issue_op(simple_processor_pkg::SLL, 24, 20, 25, 0);
    issue_op(simple_processor_pkg::SLR, 24, 20, 26, 0);
    issue_op(simple_processor_pkg::SLL, 24, 21, 27, 0);
    issue_op(simple_processor_pkg::SLR, 24, 23, 28, 0);
    issue_op(simple_processor_pkg::SLL, 24, 22, 29, 0);
    issue_op(simple_processor_pkg::SLLI, 24, 0, 25, 0);
    issue_op(simple_processor_pkg::SLLI, 24, 0, 26, 4);
    issue_op(simple_processor_pkg::SLLI, 24, 0, 27, 31);
    issue_op(simple_processor_pkg::SLRI, 24, 0, 28, 1);
    issue_op(simple_processor_pkg::SLRI, 24, 0, 29, 31);
    issue_op(simple_processor_pkg::SLLI, 24, 0, 30, 6'h3f); // Minus 1
    issue_op(simple_processor_pkg::SLRI, 24, 0, 31, 6'h20); // Minus 32
    issue_op(simple_processor_pkg::SLRI, 24, 0, 30, 6'h3a);
    repeat (40) random_op(6, 4);
    drain();

    // Writes to r0 dropped
    issue_op(simple_processor_pkg::ADDI, 0, 0, 0, 7);
    issue_op(simple_processor_pkg::ADD, 0, 0, 1, 0);
    issue_op(simple_processor_pkg::OR, 0, 24, 2, 0);
    issue_op(simple_processor_pkg::SLL, 24, 0, 3, 0);
    drain();

    // Back-to-back dependent chain
    issue_op(simple_processor_pkg::ADDI, 0, 0, 8, 3);
    issue_op(simple_processor_pkg::ADD, 8, 8, 8, 0);
    issue_op(simple_processor_pkg::SLLI, 8, 0, 8, 9);
    issue_op(simple_processor_pkg::SUB, 8, 24, 9, 0);
    issue_op(simple_processor_pkg::XOR, 9, 8, 8, 0);
    issue_op(simple_processor_pkg::SLR, 8, 20, 9, 0);
    issue_op(simple_processor_pkg::ADDI, 9, 0, 9, 6'h21);
    issue_op(simple_processor_pkg::AND, 9, 8, 10, 0);
    drain();
    idle(2);

    // Back-pressure until the issuer runs dry
    seen_before = results_seen;
    withhold = 1'b1;
    repeat (`RES_DEPTH + `RES_CREDITS) random_op(0, 10);
    idle(20);
    check_value("issue credits left", `RES_DEPTH - issued + credit_pulses, 0);
    check_value("results under back-pressure", results_seen - seen_before, `RES_CREDITS);
    check_value("res_valid without credits", res_valid, 0);
    withhold = 1'b0;
    repeat (`RES_DEPTH + `RES_CREDITS) random_op(0, 10);
    drain();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Clock and reset generator
//////////////////////////////////////////////////

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam real HALF_PERIOD  = 5.0;  // 10 ns clock
  localparam int  RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Synchronous active-low reset
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // Released away from the sampling edge
  end

endmodule

// File: design/simple_exec_top.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Execute slice top
//////////////////////////////////////////////////

module simple_exec_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Issue side
  input  logic                            iss_valid_i,
  input  simple_processor_pkg::func_t     iss_func_i,
  input  simple_processor_pkg::reg_addr_t iss_rs1_i,
  input  simple_processor_pkg::reg_addr_t iss_rs2_i,
  input  simple_processor_pkg::reg_addr_t iss_rd_i,
  input  simple_processor_pkg::imm_t      iss_imm_i,
  output logic                            iss_credit_o,
  // Result side
  input  logic                            res_credit_i,
  output logic                            res_valid_o,
  output simple_processor_pkg::reg_addr_t res_rd_o,
  output simple_processor_pkg::data_t     res_data_o
);

  simple_processor_pkg::reg_addr_t op_rs1, op_rs2;  // Read addresses
  simple_processor_pkg::func_t     op_func;
  simple_processor_pkg::imm_t      op_imm;
  simple_processor_pkg::data_t     rs1_data, rs2_data;
  simple_processor_pkg::data_t     alu_result;
  logic                            wr_en;
  simple_processor_pkg::reg_addr_t wr_addr;
  simple_processor_pkg::data_t     wr_data;

  exec_pipe i_exec_pipe (
    .clk_i, .rst_n_i,
    .iss_valid_i, .iss_func_i, .iss_rs1_i, .iss_rs2_i, .iss_rd_i, .iss_imm_i,
    .iss_credit_o,
    .res_credit_i, .res_valid_o, .res_rd_o, .res_data_o,
    .op_rs1_o     (op_rs1),
    .op_rs2_o     (op_rs2),
    .op_func_o    (op_func),
    .op_imm_o     (op_imm),
    .alu_result_i (alu_result),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data)
  );

  reg_file i_reg_file (
    .clk_i, .rst_n_i,
    .rd_addr1_i (op_rs1),
    .rd_addr2_i (op_rs2),
    .rd_data1_o (rs1_data),
    .rd_data2_o (rs2_data),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  // Read data straight into the ALU
  alu i_alu (
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .func_i     (op_func),
    .imm_i      (op_imm),
    .result_o   (alu_result)
  );

endmodule

// File: design/exec_pipe.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Execute pipe and credit control
//////////////////////////////////////////////////

`include "simple_processor_cfg.svh"

module exec_pipe (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Issue side
  input  logic                            iss_valid_i,
  input  simple_processor_pkg::func_t     iss_func_i,
  input  simple_processor_pkg::reg_addr_t iss_rs1_i,
  input  simple_processor_pkg::reg_addr_t iss_rs2_i,
  input  simple_processor_pkg::reg_addr_t iss_rd_i,
  input  simple_processor_pkg::imm_t      iss_imm_i,
  output logic                            iss_credit_o,  // One pulse per freed entry
  // Result side
  input  logic                            res_credit_i,
  output logic                            res_valid_o,
  output simple_processor_pkg::reg_addr_t res_rd_o,
  output simple_processor_pkg::data_t     res_data_o,
  // Toward register file and ALU
  output simple_processor_pkg::reg_addr_t op_rs1_o,
  output simple_processor_pkg::reg_addr_t op_rs2_o,
  output simple_processor_pkg::func_t     op_func_o,
  output simple_processor_pkg::imm_t      op_imm_o,
  input  simple_processor_pkg::data_t     alu_result_i,
  output logic                            wr_en_o,
  output simple_processor_pkg::reg_addr_t wr_addr_o,
  output simple_processor_pkg::data_t     wr_data_o
);

  logic                            iss_vld_q;  // Issue register occupied
  simple_processor_pkg::func_t     func_q;
  simple_processor_pkg::reg_addr_t rs1_q, rs2_q, rd_q;
  simple_processor_pkg::imm_t      imm_q;

  simple_processor_pkg::reg_addr_t buf_rd_q   [`RES_DEPTH];
  simple_processor_pkg::data_t     buf_data_q [`RES_DEPTH];
  simple_processor_pkg::res_ptr_t  wr_ptr_q, rd_ptr_q;
  simple_processor_pkg::res_cnt_t  count_q;       // Entries held
  simple_processor_pkg::credit_cnt_t credit_q;    // Downstream credits left
  logic push, pop, buf_empty, buf_full;

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) iss_vld_q <= 1'b0;
    else          iss_vld_q <= iss_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (iss_valid_i) begin
      func_q <= iss_func_i;
      rs1_q  <= iss_rs1_i;
      rs2_q  <= iss_rs2_i;
      rd_q   <= iss_rd_i;
      imm_q  <= iss_imm_i;
    end
  end

  assign op_rs1_o  = rs1_q;  // Operands read during the issue cycle
  assign op_rs2_o  = rs2_q;
  assign op_func_o = func_q;
  assign op_imm_o  = imm_q;

  // Writeback independent of the result side
  assign wr_en_o   = iss_vld_q;
  assign wr_addr_o = rd_q;
  assign wr_data_o = alu_result_i;

  //////////////////////////////////////////////////
  // Result buffer
  //////////////////////////////////////////////////

  assign push      = iss_vld_q;
  assign buf_empty = (count_q == '0);
  assign buf_full  = (count_q == simple_processor_pkg::res_cnt_t'(`RES_DEPTH));
  assign res_valid_o = (credit_q != '0) && !buf_empty;
  assign pop       = res_valid_o;  // Send and drop in one cycle
  assign res_rd_o   = buf_rd_q[rd_ptr_q];
  assign res_data_o = buf_data_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_rd_q[wr_ptr_q]   <= rd_q;
      buf_data_q[wr_ptr_q] <= alu_result_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      credit_q     <= simple_processor_pkg::credit_cnt_t'(`RES_CREDITS);
      iss_credit_o <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == `RES_DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == `RES_DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      count_q  <= count_q + push - pop;
      credit_q <= credit_q + res_credit_i - pop;  // Return and spend may coincide
      iss_credit_o <= pop;  // Freed slot goes back to the issuer
    end
  end

  // Issue credits cap the occupancy at the depth
  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> !buf_full)
    else $error("push into a full result buffer");

  // Consumer never returns more than it was given
  credit_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= `RES_CREDITS)
    else $error("downstream credit count above its start value");

endmodule

// File: design/reg_file.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

`include "simple_processor_cfg.svh"

module reg_file (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Read ports, combinational
  input  simple_processor_pkg::reg_addr_t rd_addr1_i,
  input  simple_processor_pkg::reg_addr_t rd_addr2_i,
  output simple_processor_pkg::data_t     rd_data1_o,
  output simple_processor_pkg::data_t     rd_data2_o,
  // Write port, lands on the next edge
  input  logic                            wr_en_i,
  input  simple_processor_pkg::reg_addr_t wr_addr_i,
  input  simple_processor_pkg::data_t     wr_data_i
);

  // No storage behind r0
  simple_processor_pkg::data_t regs_q [1:`REG_COUNT-1];

  logic wr_take;  // Write aimed at a real register

  assign wr_take = wr_en_i && (wr_addr_i != '0);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;  // All registers start at zero
      end
    end else if (wr_take) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  always_comb begin
    if (rd_addr1_i == '0) begin
      rd_data1_o = '0;  // r0 hardwired
    end else begin
      rd_data1_o = regs_q[rd_addr1_i];
    end
  end

  always_comb begin
    if (rd_addr2_i == '0) begin
      rd_data2_o = '0;
    end else begin
      rd_data2_o = regs_q[rd_addr2_i];
    end
  end

endmodule

// File: design/alu/alu.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// ALU
//////////////////////////////////////////////////

module alu (
  input  simple_processor_pkg::data_t rs1_data_i,
  input  simple_processor_pkg::data_t rs2_data_i,
  input  simple_processor_pkg::func_t func_i,
  input  simple_processor_pkg::imm_t  imm_i,
  output simple_processor_pkg::data_t result_o
);

  logic                        shift_op;     // Operation in the shift group
  simple_processor_pkg::data_t shift_res;
  simple_processor_pkg::data_t arith_res;

  alu_shift i_alu_shift (
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .func_i     (func_i),
    .imm_i      (imm_i),
    .result_o   (shift_res)
  );

  alu_arith_logic i_alu_arith_logic (
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .func_i     (func_i),
    .imm_i      (imm_i),
    .result_o   (arith_res)
  );

  // Class decode and final mux
  assign shift_op = simple_processor_pkg::is_shift(func_i);
  assign result_o = shift_op ? shift_res : arith_res;

  // Issuer must only send the ten defined codes
  always_comb begin
    if (!$isunknown(func_i)) begin
      legal_func_chk: assert (func_i inside {
        simple_processor_pkg::ADD,  simple_processor_pkg::SUB,
        simple_processor_pkg::AND,  simple_processor_pkg::OR,
        simple_processor_pkg::XOR,  simple_processor_pkg::ADDI,
        simple_processor_pkg::SLL,  simple_processor_pkg::SLLI,
        simple_processor_pkg::SLR,  simple_processor_pkg::SLRI})
        else $error("illegal operation code %0d", func_i);
    end
  end

endmodule

// File: design/alu/alu_arith_logic.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Add, subtract and logic unit
//////////////////////////////////////////////////

module alu_arith_logic (
  input  simple_processor_pkg::data_t rs1_data_i,  // First operand
  input  simple_processor_pkg::data_t rs2_data_i,  // Second operand, register form
  input  simple_processor_pkg::func_t func_i,
  input  simple_processor_pkg::imm_t  imm_i,       // Second operand for ADDI
  output simple_processor_pkg::data_t result_o
);

  simple_processor_pkg::data_t imm_ext;    // Sign-extended immediate
  simple_processor_pkg::data_t operand_b;  // Selected second operand
  simple_processor_pkg::data_t sum;
  simple_processor_pkg::data_t diff;

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  assign imm_ext   = simple_processor_pkg::sign_ext_imm(imm_i);
  assign operand_b = (func_i == simple_processor_pkg::ADDI) ? imm_ext : rs2_data_i;

  // Carry out dropped, wraps modulo 2^DATA_WIDTH
  assign sum  = rs1_data_i + operand_b;
  assign diff = rs1_data_i - operand_b;

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (func_i)
      simple_processor_pkg::ADD: begin
        result_o = sum;
      end
      simple_processor_pkg::ADDI: begin
        result_o = sum;  // Same adder, immediate operand
      end
      simple_processor_pkg::SUB: begin
        result_o = diff;
      end
      simple_processor_pkg::AND: begin
        result_o = rs1_data_i & operand_b;
      end
      simple_processor_pkg::OR: begin
        result_o = rs1_data_i | operand_b;
      end
      simple_processor_pkg::XOR: begin
        result_o = rs1_data_i ^ operand_b;
      end
      default: begin
        result_o = '0;  // Shift ops handled elsewhere
      end
    endcase
  end

endmodule

// File: design/alu/alu_shift.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Shift unit
//////////////////////////////////////////////////

`include "simple_processor_cfg.svh"

module alu_shift (
  input  simple_processor_pkg::data_t rs1_data_i,  // Value to shift
  input  simple_processor_pkg::data_t rs2_data_i,  // Amount for SLL and SLR
  input  simple_processor_pkg::func_t func_i,
  input  simple_processor_pkg::imm_t  imm_i,       // Amount for SLLI and SLRI
  output simple_processor_pkg::data_t result_o
);

  logic                        shift_r;     // High for right, low for left
  logic                        over_range;  // Amount at or past the width
  simple_processor_pkg::data_t imm_ext;     // Sign-extended immediate
  simple_processor_pkg::data_t shift_amt;   // Selected shift amount

  assign imm_ext = simple_processor_pkg::sign_ext_imm(imm_i);

  //////////////////////////////////////////////////
  // Direction and amount select
  //////////////////////////////////////////////////

  always_comb begin
    shift_r   = 1'b0;
    shift_amt = rs2_data_i;
    case (func_i)
      simple_processor_pkg::SLL: begin
        shift_r   = 1'b0;
        shift_amt = rs2_data_i;
      end
      simple_processor_pkg::SLLI: begin
        shift_r   = 1'b0;
        shift_amt = imm_ext;  // Negative values land past the width
      end
      simple_processor_pkg::SLR: begin
        shift_r   = 1'b1;
        shift_amt = rs2_data_i;
      end
      simple_processor_pkg::SLRI: begin
        shift_r   = 1'b1;
        shift_amt = imm_ext;
      end
      default: begin
        shift_r   = 1'b0;  // Arithmetic ops, result unused
        shift_amt = rs2_data_i;
      end
    endcase
  end

  // Full amount counts, not just the low bits
  assign over_range = (shift_amt >= `DATA_WIDTH);

  assign result_o = over_range ? '0 :
                    shift_r    ? (rs1_data_i >> shift_amt) :
                                 (rs1_data_i << shift_amt);

  // Width sanity check at start of simulation
  initial begin
    if (`DATA_WIDTH != 32) begin
      $warning("%m: DATA_WIDTH is %0d, shift unit is tuned for 32", `DATA_WIDTH);
    end
  end

endmodule

// File: common/simple_processor_pkg.sv
//////////////////////////////////////////////////
// Execute slice types
//////////////////////////////////////////////////

package simple_processor_pkg;

`include "simple_processor_cfg.svh"

  // Operation codes, arithmetic group first
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    ADDI = 4'd5,
    SLL  = 4'd6,
    SLLI = 4'd7,
    SLR  = 4'd8,  // Logical right
    SLRI = 4'd9
  } func_t;

  typedef logic [`DATA_WIDTH-1:0]            data_t;
  typedef logic [$clog2(`REG_COUNT)-1:0]     reg_addr_t;
  typedef logic [`IMM_WIDTH-1:0]             imm_t;

  // Result buffer bookkeeping
  typedef logic [$clog2(`RES_DEPTH)-1:0]     res_ptr_t;
  typedef logic [$clog2(`RES_DEPTH+1)-1:0]   res_cnt_t;
  typedef logic [$clog2(`RES_CREDITS+1)-1:0] credit_cnt_t;

  // Immediate widened to a full data word
  function automatic data_t sign_ext_imm(imm_t imm);
    return {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
  endfunction

  // Shift group membership
  function automatic logic is_shift(func_t func);
    return (func == SLL) || (func == SLLI) || (func == SLR) || (func == SLRI);
  endfunction

endpackage

// File: common/simple_processor_cfg.svh
//////////////////////////////////////////////////
// Execute slice configuration
//////////////////////////////////////////////////

`ifndef SIMPLE_PROCESSOR_CFG_SVH
`define SIMPLE_PROCESSOR_CFG_SVH

// Register and data width
`define DATA_WIDTH 32

// Architectural registers, r0 included
`define REG_COUNT 32

// Raw immediate field width
`define IMM_WIDTH 6

// Result buffer entries, equal to the issuer's starting credits
`define RES_DEPTH 4

// Starting credits toward the downstream consumer
`define RES_CREDITS 2

`endif
